/* source/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data and address width
`define XLEN 32

// multiplier bits retired per cycle
`define MUL_STEP_BITS 8

// quotient bits per cycle
`define DIV_STEP_BITS 2

`endif

/* source/cpu_pkg.sv */
`include "cpu_macros.svh"

package cpu_pkg;

	// compare codes return 0 or 1 in bit 0
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
		ALU_SRA, ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_GE, ALU_GEU
	} alu_op_t;

	typedef enum logic [2:0] {
		MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
	} mem_op_t;

	typedef enum logic [1:0] {MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU} mul_op_t;

	typedef enum logic [1:0] {DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU} div_op_t;

	typedef enum logic [2:0] {SEL_ALU, SEL_MEM, SEL_MUL, SEL_DIV} wb_src_t;

	// decoded instruction from decode
	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] ir;
		logic [`XLEN-1:0] imm;
		logic [5:0] rs1_addr;
		logic [`XLEN-1:0] rs1_data;
		logic rs1_access;
		logic [5:0] rs2_addr;
		logic [`XLEN-1:0] rs2_data;
		logic rs2_access;
		logic [5:0] rd_addr;
		logic rd_access;
		logic sel_pc;
		logic sel_imm;
		wb_src_t wb_src;
		alu_op_t alu_op;
		mem_op_t mem_op;
		mul_op_t mul_op;
		div_op_t div_op;
		logic jump_ena;
		logic jump_ind;
		logic jump_alw;
		logic [1:0] fetch_resp;
		logic illegal_inst;
	} id_ex_t;

	// EX/MEM bundle
	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] ir;
		logic [`XLEN-1:0] imm;
		logic [5:0] rd_addr;
		logic [`XLEN-1:0] rd_data;
		logic rd_access;
		wb_src_t wb_src;
		mem_op_t mem_op;
		logic [1:0] fetch_resp;
		logic illegal_inst;
		logic maligned_inst;
		logic maligned_load;
		logic maligned_store;
	} ex_mem_t;

	typedef struct packed {
		logic [5:0] rd_addr;
		logic [`XLEN-1:0] rd_data;
		logic rd_access;
	} fwd_t;

	typedef struct packed {
		logic [`XLEN-1:0] addr;
		logic [2:0] prot;
	} dmem_addr_t;

	typedef struct packed {
		logic [`XLEN-1:0] data;
		logic [3:0] strb;
	} dmem_wdata_t;

endpackage

/* source/alu.sv */
`include "cpu_macros.svh"

module alu (
	input cpu_pkg::alu_op_t op,
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	output logic [`XLEN-1:0] y
);
	import cpu_pkg::*;

	logic [4:0] shamt;
	logic lt_s;
	logic lt_u;

	assign shamt = b[4:0];
	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;

	always_comb begin
		y = '0;
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_SLL: y = a << shamt;
			ALU_SRL: y = a >> shamt;
			ALU_SRA: y = $signed(a) >>> shamt;
			ALU_XOR: y = a ^ b;
			ALU_OR: y = a | b;
			ALU_AND: y = a & b;
			// compares, also used by the branches
			ALU_SLT: y[0] = lt_s;
			ALU_SLTU: y[0] = lt_u;
			ALU_EQ: y[0] = a == b;
			ALU_NE: y[0] = a != b;
			ALU_GE: y[0] = !lt_s;
			ALU_GEU: y[0] = !lt_u;
			default: y = '0;
		endcase
	end

endmodule

/* source/int_multiplier.sv */
`include "cpu_macros.svh"

module int_multiplier (
	input logic clk,
	input logic reset,
	input logic valid_in,
	output logic ready_out,
	output logic valid_out,
	input logic ready_in,
	input cpu_pkg::mul_op_t op,
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	output logic [`XLEN-1:0] y
);
	import cpu_pkg::*;

	localparam int STEPS = `XLEN / `MUL_STEP_BITS;
	localparam int CNT_W = $clog2(STEPS);

	logic busy;
	logic [CNT_W-1:0] cnt;
	logic last_step;
	logic accept;
	logic signed [2*`XLEN-1:0] mcand;
	logic [`XLEN-1:0] mplier;
	logic signed [2*`XLEN-1:0] acc;
	logic signed [`MUL_STEP_BITS:0] digit;
	logic b_signed;
	logic high_word;

	assign accept = valid_in && ready_out;
	assign ready_out = !busy && !valid_out;
	assign last_step = cnt == CNT_W'(STEPS - 1);

	// top chunk of a signed multiplier has negative weight
	assign digit = {b_signed && last_step && mplier[`MUL_STEP_BITS-1],
		mplier[`MUL_STEP_BITS-1:0]};

	assign y = high_word ? acc[2*`XLEN-1:`XLEN] : acc[`XLEN-1:0];

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			valid_out <= 1'b0;
			cnt <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			cnt <= '0;
		end else if (busy) begin
			cnt <= cnt + 1'b1;
			if (last_step) begin
				busy <= 1'b0;
				valid_out <= 1'b1;
			end
		end else if (valid_out && ready_in) begin
			valid_out <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			// sign-extend the multiplicand for MULH and MULHSU
			if (op == MUL_MULH || op == MUL_MULHSU)
				mcand <= {{`XLEN{a[`XLEN-1]}}, a};
			else
				mcand <= {{`XLEN{1'b0}}, a};
			mplier <= b;
			acc <= '0;
			b_signed <= op == MUL_MULH;
			high_word <= op != MUL_MUL;
		end else if (busy) begin
			acc <= acc + mcand * digit;
			mcand <= mcand <<< `MUL_STEP_BITS;
			mplier <= mplier >> `MUL_STEP_BITS;
		end
	end

	// decode only strobes a free unit
	a_strobe_when_free: assert property (
		@(posedge clk) disable iff (reset) valid_in |-> ready_out);

endmodule

/* source/int_divider.sv */
`include "cpu_macros.svh"

module int_divider (
	input logic clk,
	input logic reset,
	input logic valid_in,
	output logic ready_out,
	output logic valid_out,
	input logic ready_in,
	input cpu_pkg::div_op_t op,
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	output logic [`XLEN-1:0] y
);
	import cpu_pkg::*;

	localparam int STEPS = `XLEN / `DIV_STEP_BITS;
	localparam int CNT_W = $clog2(STEPS);

	logic busy;
	logic fix;
	logic [CNT_W-1:0] cnt;
	logic accept;
	logic signed_op;
	logic a_neg;
	logic b_neg;
	logic [`XLEN:0] rem;
	logic [`XLEN:0] rem_nx;
	logic [`XLEN-1:0] quo;
	logic [`XLEN-1:0] quo_nx;
	logic [`XLEN-1:0] dvs;
	logic neg_q;
	logic neg_r;
	logic sel_rem;
	logic [`XLEN-1:0] res;

	assign accept = valid_in && ready_out;
	assign ready_out = !busy && !fix && !valid_out;
	assign signed_op = op == DIV_DIV || op == DIV_REM;
	assign a_neg = signed_op && a[`XLEN-1];
	assign b_neg = signed_op && b[`XLEN-1];
	assign y = res;

	// restoring steps, dividend shifts out of quo as quotient shifts in
	always_comb begin
		rem_nx = rem;
		quo_nx = quo;
		for (int i = 0; i < `DIV_STEP_BITS; i++) begin
			rem_nx = {rem_nx[`XLEN-1:0], quo_nx[`XLEN-1]};
			quo_nx = {quo_nx[`XLEN-2:0], 1'b0};
			if (rem_nx >= {1'b0, dvs}) begin
				rem_nx = rem_nx - {1'b0, dvs};
				quo_nx[0] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			fix <= 1'b0;
			valid_out <= 1'b0;
			cnt <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			cnt <= '0;
		end else if (busy) begin
			cnt <= cnt + 1'b1;
			if (cnt == CNT_W'(STEPS - 1)) begin
				busy <= 1'b0;
				fix <= 1'b1;
			end
		end else if (fix) begin
			fix <= 1'b0;
			valid_out <= 1'b1;
		end else if (valid_out && ready_in) begin
			valid_out <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			quo <= a_neg ? -a : a;
			dvs <= b_neg ? -b : b;
			rem <= '0;
			// divide by zero keeps the all-ones quotient
			neg_q <= (a_neg ^ b_neg) && |b;
			neg_r <= a_neg;
			sel_rem <= op == DIV_REM || op == DIV_REMU;
		end else if (busy) begin
			rem <= rem_nx;
			quo <= quo_nx;
		end else if (fix) begin
			// overflow case falls out of the unsigned magnitudes
			if (sel_rem)
				res <= neg_r ? -rem[`XLEN-1:0] : rem[`XLEN-1:0];
			else
				res <= neg_q ? -quo : quo;
		end
	end

	a_hold_result: assert property (
		@(posedge clk) disable iff (reset) valid_out && !ready_in |=> valid_out);

endmodule

/* source/ex_stage.sv */
`include "cpu_macros.svh"

module ex_stage (
	input logic clk,
	input logic reset,
	input logic valid_in,
	output logic ready_out,
	output logic valid_out,
	input logic ready_in,
	input logic valid_in_mul,
	output logic ready_out_mul,
	input logic valid_in_div,
	output logic ready_out_div,
	input cpu_pkg::id_ex_t id,
	input cpu_pkg::fwd_t mem_fwd,
	output logic jump_taken,
	output logic [`XLEN-1:0] jump_addr,
	output cpu_pkg::ex_mem_t ex,
	output cpu_pkg::dmem_addr_t dmem_aw,
	output cpu_pkg::dmem_addr_t dmem_ar,
	output cpu_pkg::dmem_wdata_t dmem_w,
	output logic dmem_awvalid,
	output logic dmem_wvalid,
	output logic dmem_arvalid,
	input logic dmem_awready,
	input logic dmem_wready,
	input logic dmem_arready
);
	import cpu_pkg::*;

	fwd_t ex_fwd;
	ex_mem_t ex_next;
	logic hit1_ex;
	logic hit1_mem;
	logic hit2_ex;
	logic hit2_mem;
	logic load_use;
	logic stall;
	logic unit_ready;
	logic accept;
	logic is_mem;
	logic valid_out_mul;
	logic valid_out_div;
	logic maligned_inst;
	logic maligned_load;
	logic maligned_store;
	logic [`XLEN-1:0] rs1_data;
	logic [`XLEN-1:0] rs2_data;
	logic [`XLEN-1:0] a;
	logic [`XLEN-1:0] b;
	logic [`XLEN-1:0] alu_out;
	logic [`XLEN-1:0] mul_out;
	logic [`XLEN-1:0] div_out;
	logic [`XLEN-1:0] rd_data;
	logic [`XLEN-1:0] req_addr;
	logic [`XLEN-1:0] req_wdata;
	logic [3:0] strb;

	function automatic logic src_hit(input logic [5:0] addr, input logic access, input fwd_t src);
		return access && |addr && src.rd_access && addr == src.rd_addr;
	endfunction

	assign ex_fwd = '{rd_addr: ex.rd_addr, rd_data: ex.rd_data, rd_access: ex.rd_access};
	assign hit1_ex = src_hit(id.rs1_addr, id.rs1_access, ex_fwd);
	assign hit1_mem = src_hit(id.rs1_addr, id.rs1_access, mem_fwd);
	assign hit2_ex = src_hit(id.rs2_addr, id.rs2_access, ex_fwd);
	assign hit2_mem = src_hit(id.rs2_addr, id.rs2_access, mem_fwd);

	// EX register wins over the memory stage
	assign rs1_data = hit1_ex ? ex.rd_data : (hit1_mem ? mem_fwd.rd_data : id.rs1_data);
	assign rs2_data = hit2_ex ? ex.rd_data : (hit2_mem ? mem_fwd.rd_data : id.rs2_data);

	assign load_use = (hit1_ex || hit2_ex) && ex.wb_src == SEL_MEM;
	assign stall = load_use || (id.wb_src == SEL_MUL && !valid_out_mul) ||
		(id.wb_src == SEL_DIV && !valid_out_div);
	assign ready_out = ready_in && !stall;
	assign unit_ready = ready_in && !load_use;
	assign accept = valid_in && ready_out;
	assign is_mem = id.wb_src == SEL_MEM;

	assign a = id.sel_pc ? id.pc : rs1_data;
	assign b = id.sel_imm ? id.imm : rs2_data;

	assign jump_taken = id.jump_ena && (alu_out[0] || id.jump_alw) && !load_use;
	assign jump_addr = id.jump_ind ? (rs1_data + id.imm) & ~`XLEN'(1) : id.pc + id.imm;
	assign maligned_inst = jump_taken && |jump_addr[1:0];

	always_comb begin
		maligned_load = 1'b0;
		maligned_store = 1'b0;
		if (is_mem) begin
			case (id.mem_op)
				MEM_LH, MEM_LHU: maligned_load = &alu_out[1:0];
				MEM_LW: maligned_load = |alu_out[1:0];
				MEM_SH: maligned_store = &alu_out[1:0];
				MEM_SW: maligned_store = |alu_out[1:0];
				default: ;
			endcase
		end
	end

	always_comb begin
		case (id.wb_src)
			SEL_MUL: rd_data = mul_out;
			SEL_DIV: rd_data = div_out;
			// load data arrives in the memory stage
			SEL_MEM: rd_data = '0;
			default: rd_data = alu_out;
		endcase
	end

	assign ex_next = '{pc: id.pc, ir: id.ir, imm: id.imm, rd_addr: id.rd_addr,
		rd_data: rd_data, rd_access: id.rd_access, wb_src: id.wb_src,
		mem_op: id.mem_op, fetch_resp: id.fetch_resp, illegal_inst: id.illegal_inst,
		maligned_inst: maligned_inst, maligned_load: maligned_load,
		maligned_store: maligned_store};

	always_comb begin
		strb = 4'b0000;
		if (dmem_awvalid) begin
			case (ex.mem_op)
				MEM_SB: strb = 4'b0001 << req_addr[1:0];
				MEM_SH: strb = 4'b0011 << req_addr[1:0];
				MEM_SW: strb = 4'b1111 << req_addr[1:0];
				default: strb = 4'b0000;
			endcase
		end
	end

	assign dmem_aw = '{addr: req_addr, prot: 3'b010};
	assign dmem_ar = '{addr: req_addr, prot: 3'b010};
	assign dmem_w = '{data: req_wdata, strb: strb};

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			valid_out <= 1'b0;
			ex <= '0;
			dmem_awvalid <= 1'b0;
			dmem_wvalid <= 1'b0;
			dmem_arvalid <= 1'b0;
		end else if (accept) begin
			valid_out <= 1'b1;
			ex <= ex_next;
			dmem_arvalid <= is_mem && id.rd_access;
			dmem_awvalid <= is_mem && !id.rd_access;
			dmem_wvalid <= is_mem && !id.rd_access;
		end else if (valid_out && ready_in) begin
			valid_out <= 1'b0;
			ex <= '0;
			dmem_awvalid <= 1'b0;
			dmem_wvalid <= 1'b0;
			dmem_arvalid <= 1'b0;
		end else begin
			if (dmem_awready)
				dmem_awvalid <= 1'b0;
			if (dmem_wready)
				dmem_wvalid <= 1'b0;
			if (dmem_arready)
				dmem_arvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr <= alu_out;
			req_wdata <= rs2_data;
		end
	end

	alu u_alu (.op(id.alu_op), .a(a), .b(b), .y(alu_out));

	int_multiplier u_mul (
		.clk(clk), .reset(reset),
		.valid_in(valid_in_mul), .ready_out(ready_out_mul),
		.valid_out(valid_out_mul), .ready_in(unit_ready),
		.op(id.mul_op), .a(a), .b(b), .y(mul_out)
	);

	int_divider u_div (
		.clk(clk), .reset(reset),
		.valid_in(valid_in_div), .ready_out(ready_out_div),
		.valid_out(valid_out_div), .ready_in(unit_ready),
		.op(id.div_op), .a(a), .b(b), .y(div_out)
	);

	a_ex_stable: assert property (@(posedge clk) disable iff (reset)
		valid_out && !ready_in |=> valid_out && $stable(ex));

	// store address and data go out as a pair
	a_store_pair: assert property (@(posedge clk) disable iff (reset)
		$rose(dmem_awvalid) || $rose(dmem_wvalid) |-> dmem_awvalid && dmem_wvalid);

endmodule

/* tb/ex_checker.sv */
`include "cpu_macros.svh"

module ex_checker (
	input logic clk,
	input logic reset,
	input logic valid_in,
	input logic ready_out,
	input logic valid_out,
	input logic ready_in,
	input logic valid_in_mul,
	input logic ready_out_mul,
	input logic valid_in_div,
	input logic ready_out_div,
	input cpu_pkg::id_ex_t id,
	input cpu_pkg::fwd_t mem_fwd,
	input logic jump_taken,
	input logic [`XLEN-1:0] jump_addr,
	input cpu_pkg::ex_mem_t ex,
	input cpu_pkg::dmem_addr_t dmem_aw,
	input cpu_pkg::dmem_addr_t dmem_ar,
	input cpu_pkg::dmem_wdata_t dmem_w,
	input logic dmem_awvalid,
	input logic dmem_wvalid,
	input logic dmem_arvalid,
	input logic dmem_awready,
	input logic dmem_wready,
	input logic dmem_arready,
	output int errors,
	output int checks,
	output int pending
);
	import cpu_pkg::*;

	// cycles from unit accept to a valid result
	localparam int MUL_CYCLES = `XLEN / `MUL_STEP_BITS;
	localparam int DIV_CYCLES = `XLEN / `DIV_STEP_BITS + 1;

	ex_mem_t exp_q[$];
	ex_mem_t model_ex;
	ex_mem_t nxt;
	logic [`XLEN-1:0] op1;
	logic [`XLEN-1:0] op2;
	logic [`XLEN-1:0] a;
	logic [`XLEN-1:0] b;
	logic [`XLEN-1:0] alu_y;
	logic [`XLEN-1:0] tgt;
	logic [`XLEN-1:0] mul_res;
	logic [`XLEN-1:0] div_res;
	logic [`XLEN-1:0] req_addr;
	logic [`XLEN-1:0] req_data;
	logic [3:0] req_strb;
	mem_op_t req_op;
	logic hz;
	logic exp_taken;
	logic exp_ready;
	logic m_awv;
	logic m_wv;
	logic m_arv;
	logic mul_held;
	logic div_held;
	logic mul_done;
	logic div_done;
	int mul_left;
	int div_left;

	task automatic compare_word(input string name, input logic [159:0] exp,
		input logic [159:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Fail %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Fail %s expected %b actual %b", name, exp, act);
		end
	endtask

	function automatic logic ex_hit(input logic [5:0] r, input logic acc, input ex_mem_t e);
		return acc && r != 6'd0 && e.rd_access && e.rd_addr == r;
	endfunction

	// EX register first, then the memory stage
	function automatic logic [`XLEN-1:0] fwd_model(input logic [5:0] r, input logic acc,
		input logic [`XLEN-1:0] own, input ex_mem_t e, input fwd_t m);
		if (!acc || r == 6'd0)
			return own;
		if (e.rd_access && e.rd_addr == r)
			return e.rd_data;
		if (m.rd_access && m.rd_addr == r)
			return m.rd_data;
		return own;
	endfunction

	function automatic logic [`XLEN-1:0] alu_model(input alu_op_t op,
		input logic [`XLEN-1:0] x, input logic [`XLEN-1:0] y);
		case (op)
			ALU_ADD: return x + y;
			ALU_SUB: return x - y;
			ALU_SLL: return x << y[4:0];
			ALU_SRL: return x >> y[4:0];
			ALU_SRA: return `XLEN'($signed(x) >>> y[4:0]);
			ALU_XOR: return x ^ y;
			ALU_OR: return x | y;
			ALU_AND: return x & y;
			ALU_SLT: return `XLEN'($signed(x) < $signed(y));
			ALU_SLTU: return `XLEN'(x < y);
			ALU_EQ: return `XLEN'(x == y);
			ALU_NE: return `XLEN'(x != y);
			ALU_GE: return `XLEN'($signed(x) >= $signed(y));
			ALU_GEU: return `XLEN'(x >= y);
			default: return '0;
		endcase
	endfunction

	function automatic logic [`XLEN-1:0] mul_model(input mul_op_t op,
		input logic [`XLEN-1:0] x, input logic [`XLEN-1:0] y);
		logic [2*`XLEN-1:0] xe;
		logic [2*`XLEN-1:0] ye;
		logic [2*`XLEN-1:0] p;
		xe = {{`XLEN{x[`XLEN-1] && (op == MUL_MULH || op == MUL_MULHSU)}}, x};
		ye = {{`XLEN{y[`XLEN-1] && op == MUL_MULH}}, y};
		p = xe * ye;
		return op == MUL_MUL ? p[`XLEN-1:0] : p[2*`XLEN-1:`XLEN];
	endfunction

	function automatic logic [`XLEN-1:0] div_model(input div_op_t op,
		input logic [`XLEN-1:0] x, input logic [`XLEN-1:0] y);
		logic signed [`XLEN-1:0] s;
		logic ovf;
		ovf = x == {1'b1, {(`XLEN-1){1'b0}}} && y == '1;
		if (y == '0)
			return (op == DIV_DIV || op == DIV_DIVU) ? '1 : x;
		case (op)
			DIV_DIV: begin
				if (ovf)
					return x;
				s = $signed(x) / $signed(y);
				return s;
			end
			DIV_REM: begin
				if (ovf)
					return '0;
				s = $signed(x) % $signed(y);
				return s;
			end
			DIV_DIVU: return x / y;
			default: return x % y;
		endcase
	endfunction

	function automatic logic [3:0] strb_model(input mem_op_t op, input logic [1:0] lo);
		case (op)
			MEM_SB: return 4'b0001 << lo;
			MEM_SH: return 4'b0011 << lo;
			MEM_SW: return 4'b1111 << lo;
			default: return 4'b0000;
		endcase
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			exp_q.delete();
			m_awv = 1'b0;
			m_wv = 1'b0;
			m_arv = 1'b0;
			mul_held = 1'b0;
			div_held = 1'b0;
			mul_left = 0;
			div_left = 0;
			errors = 0;
			checks = 0;
			pending = 0;
		end else begin
			model_ex = exp_q.size() != 0 ? exp_q[0] : '0;
			op1 = fwd_model(id.rs1_addr, id.rs1_access, id.rs1_data, model_ex, mem_fwd);
			op2 = fwd_model(id.rs2_addr, id.rs2_access, id.rs2_data, model_ex, mem_fwd);
			hz = model_ex.wb_src == SEL_MEM && (ex_hit(id.rs1_addr, id.rs1_access, model_ex) ||
				ex_hit(id.rs2_addr, id.rs2_access, model_ex));
			a = id.sel_pc ? id.pc : op1;
			b = id.sel_imm ? id.imm : op2;
			alu_y = alu_model(id.alu_op, a, b);
			exp_taken = id.jump_ena && (alu_y[0] || id.jump_alw) && !hz;
			tgt = id.jump_ind ? (op1 + id.imm) & ~`XLEN'(1) : id.pc + id.imm;

			mul_done = mul_held && mul_left == 0;
			div_done = div_held && div_left == 0;
			exp_ready = ready_in && !hz && !(id.wb_src == SEL_MUL && !mul_done) &&
				!(id.wb_src == SEL_DIV && !div_done);

			compare_bit("ready_out_mul", !mul_held, ready_out_mul);
			compare_bit("ready_out_div", !div_held, ready_out_div);

			// a unit frees itself on its own handshake
			if (mul_done && ready_in && !hz)
				mul_held = 1'b0;
			if (div_done && ready_in && !hz)
				div_held = 1'b0;
			if (mul_left != 0)
				mul_left--;
			if (div_left != 0)
				div_left--;

			// units latch their operands on the strobe
			if (valid_in_mul) begin
				mul_res = mul_model(id.mul_op, a, b);
				mul_held = 1'b1;
				mul_left = MUL_CYCLES;
			end
			if (valid_in_div) begin
				div_res = div_model(id.div_op, a, b);
				div_held = 1'b1;
				div_left = DIV_CYCLES;
			end

			if (valid_in) begin
				compare_bit("jump_taken", exp_taken, jump_taken);
				compare_word("jump_addr", 160'(tgt), 160'(jump_addr));
				compare_bit("ready_out", exp_ready, ready_out);
			end

			compare_bit("valid_out", exp_q.size() != 0, valid_out);
			compare_bit("dmem_awvalid", m_awv, dmem_awvalid);
			compare_bit("dmem_wvalid", m_wv, dmem_wvalid);
			compare_bit("dmem_arvalid", m_arv, dmem_arvalid);
			if (m_awv)
				compare_word("dmem_aw", 160'({req_addr, 3'b010}), 160'(dmem_aw));
			if (m_arv)
				compare_word("dmem_ar", 160'({req_addr, 3'b010}), 160'(dmem_ar));
			if (m_wv) begin
				req_strb = m_awv ? strb_model(req_op, req_addr[1:0]) : 4'b0000;
				compare_word("dmem_w", 160'({req_data, req_strb}), 160'(dmem_w));
			end

			if (valid_out && ready_in) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("output handshake with no instruction accepted");
				end else begin
					compare_word("ex_bundle", 160'(exp_q[0]), 160'(ex));
					void'(exp_q.pop_front());
				end
				m_awv = 1'b0;
				m_wv = 1'b0;
				m_arv = 1'b0;
			end else begin
				if (dmem_awready)
					m_awv = 1'b0;
				if (dmem_wready)
					m_wv = 1'b0;
				if (dmem_arready)
					m_arv = 1'b0;
			end

			if (valid_in && ready_out) begin
				nxt = '0;
				nxt.pc = id.pc;
				nxt.ir = id.ir;
				nxt.imm = id.imm;
				nxt.rd_addr = id.rd_addr;
				nxt.rd_access = id.rd_access;
				nxt.wb_src = id.wb_src;
				nxt.mem_op = id.mem_op;
				nxt.fetch_resp = id.fetch_resp;
				nxt.illegal_inst = id.illegal_inst;
				case (id.wb_src)
					SEL_MUL: nxt.rd_data = mul_res;
					SEL_DIV: nxt.rd_data = div_res;
					SEL_MEM: nxt.rd_data = '0;
					default: nxt.rd_data = alu_y;
				endcase
				nxt.maligned_inst = exp_taken && tgt[1:0] != 2'b00;
				if (id.wb_src == SEL_MEM) begin
					nxt.maligned_load = ((id.mem_op == MEM_LH || id.mem_op == MEM_LHU) &&
						alu_y[1:0] == 2'b11) || (id.mem_op == MEM_LW && alu_y[1:0] != 2'b00);
					nxt.maligned_store = (id.mem_op == MEM_SH && alu_y[1:0] == 2'b11) ||
						(id.mem_op == MEM_SW && alu_y[1:0] != 2'b00);
				end
				exp_q.push_back(nxt);
				m_arv = id.wb_src == SEL_MEM && id.rd_access;
				m_awv = id.wb_src == SEL_MEM && !id.rd_access;
				m_wv = m_awv;
				req_addr = alu_y;
				req_data = op2;
				req_op = id.mem_op;
			end
			pending = exp_q.size();
		end
	end

endmodule

/* tb/ex_stage_tb.sv */
`include "cpu_macros.svh"

module ex_stage_tb;
	import cpu_pkg::*;

	localparam int NUM_INST = 2000;
	localparam int CYCLE_LIMIT = NUM_INST * 40;

	logic clk;
	logic reset;
	logic valid_in;
	logic ready_out;
	logic valid_out;
	logic ready_in;
	logic valid_in_mul;
	logic ready_out_mul;
	logic valid_in_div;
	logic ready_out_div;
	id_ex_t id;
	fwd_t mem_fwd;
	logic jump_taken;
	logic [`XLEN-1:0] jump_addr;
	ex_mem_t ex;
	dmem_addr_t dmem_aw;
	dmem_addr_t dmem_ar;
	dmem_wdata_t dmem_w;
	logic dmem_awvalid;
	logic dmem_wvalid;
	logic dmem_arvalid;
	logic dmem_awready;
	logic dmem_wready;
	logic dmem_arready;
	int errors;
	int checks;
	int pending;
	int cycles;
	logic [31:0] lcg_state;

	ex_stage u_dut (.*);

	ex_checker u_check (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state ^ (lcg_state >> 15);
	endfunction

	// corner values show up often for the divider
	function automatic logic [`XLEN-1:0] pick_data();
		logic [31:0] r;
		r = next_rand();
		case (r[2:0])
			3'd0: return 32'h0000_0000;
			3'd1: return 32'h8000_0000;
			3'd2: return 32'hffff_ffff;
			3'd3: return {28'd0, r[7:4]};
			default: return next_rand();
		endcase
	endfunction

	task automatic drive_random();
		logic [31:0] r;
		r = next_rand();
		ready_in = r[1:0] != 2'b00;
		dmem_awready = r[2];
		dmem_wready = r[3];
		dmem_arready = r[4];
		mem_fwd.rd_addr = 6'(r[7:5]);
		mem_fwd.rd_access = r[8];
		mem_fwd.rd_data = pick_data();
	endtask

	task automatic make_inst(output id_ex_t inst);
		logic [31:0] r;
		logic [31:0] k;
		r = next_rand();
		k = next_rand();
		inst = '0;
		inst.pc = next_rand() & 32'hffff_fffc;
		inst.ir = next_rand();
		inst.imm = {{20{k[11]}}, k[11:0]};
		// few registers, so hazards are frequent
		inst.rs1_addr = 6'(r[2:0]);
		inst.rs2_addr = 6'(r[5:3]);
		inst.rd_addr = 6'(r[8:6]);
		inst.rs1_data = pick_data();
		inst.rs2_data = pick_data();
		inst.fetch_resp = r[10:9];
		inst.illegal_inst = r[11];
		inst.wb_src = SEL_ALU;
		inst.alu_op = ALU_ADD;
		case (r[14:12])
			3'd0, 3'd1: begin
				inst.rs1_access = 1'b1;
				inst.rs2_access = 1'b1;
				inst.rd_access = 1'b1;
				inst.alu_op = alu_op_t'(r[19:16] % 4'd14);
			end
			3'd2: begin
				inst.rs1_access = 1'b1;
				inst.sel_imm = 1'b1;
				inst.rd_access = 1'b1;
				inst.alu_op = alu_op_t'(r[19:16] % 4'd14);
			end
			3'd3: begin
				inst.rs1_access = 1'b1;
				inst.rs2_access = 1'b1;
				inst.jump_ena = 1'b1;
				inst.alu_op = r[18] ? alu_op_t'(4'd10 + 4'(r[17:16])) :
					(r[16] ? ALU_SLT : ALU_SLTU);
			end
			3'd4: begin
				// JAL and JALR, rd gets pc plus imm
				inst.jump_ena = 1'b1;
				inst.jump_alw = 1'b1;
				inst.rd_access = 1'b1;
				inst.sel_pc = 1'b1;
				inst.sel_imm = 1'b1;
				inst.jump_ind = r[16];
				inst.rs1_access = r[16];
			end
			3'd5: begin
				inst.wb_src = SEL_MEM;
				inst.rs1_access = 1'b1;
				inst.sel_imm = 1'b1;
				inst.rd_access = 1'b1;
				inst.mem_op = mem_op_t'(r[18:16] % 3'd5);
			end
			3'd6: begin
				inst.wb_src = SEL_MEM;
				inst.rs1_access = 1'b1;
				inst.rs2_access = 1'b1;
				inst.sel_imm = 1'b1;
				inst.mem_op = mem_op_t'(3'd5 + 3'(r[17:16] % 2'd3));
			end
			default: begin
				inst.rs1_access = 1'b1;
				inst.rs2_access = 1'b1;
				inst.rd_access = 1'b1;
				inst.wb_src = r[16] ? SEL_MUL : SEL_DIV;
				inst.mul_op = mul_op_t'(r[18:17]);
				inst.div_op = div_op_t'(r[20:19]);
			end
		endcase
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles with %0d errors", cycles, errors);
			$display("Something failed");
			$finish;
		end
	end

	initial begin
		id_ex_t inst;
		logic taken;
		cycles = 0;
		lcg_state = 32'h616c;
		reset = 1'b1;
		valid_in = 1'b0;
		valid_in_mul = 1'b0;
		valid_in_div = 1'b0;
		id = '0;
		mem_fwd = '0;
		ready_in = 1'b0;
		dmem_awready = 1'b0;
		dmem_wready = 1'b0;
		dmem_arready = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int n = 0; n < NUM_INST; n++) begin
			make_inst(inst);
			id = inst;
			valid_in = 1'b1;
			valid_in_mul = inst.wb_src == SEL_MUL;
			valid_in_div = inst.wb_src == SEL_DIV;
			drive_random();
			taken = 1'b0;
			while (!taken) begin
				@(posedge clk);
				taken = ready_out;
				@(negedge clk);
				// unit strobe lasts one cycle
				valid_in_mul = 1'b0;
				valid_in_div = 1'b0;
				drive_random();
			end
		end
		valid_in = 1'b0;
		while (pending != 0 || valid_out) begin
			@(posedge clk);
			@(negedge clk);
			drive_random();
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* tb.f */
+incdir+source
source/cpu_pkg.sv
source/alu.sv
source/int_multiplier.sv
source/int_divider.sv
source/ex_stage.sv
tb/ex_checker.sv
tb/ex_stage_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ex_stage_tb -f tb.f -o ex_sim

./obj_dir/ex_sim | tee sim.log

if grep -q "Everything OK" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
